//--- source/menuPkg.sv
package menuPkg;

	////////////////////
	// Menu text lines

	// Also the line index into the menu text ROM
	typedef enum logic [2:0]
	{
		TitleMain,
		OptDisplayLocal,
		OptModifyLocal,
		OptClearLocal,
		TitleSure,
		OptYes,
		OptNo
	} menuId_t;

	// Number of text lines held in the ROM
	localparam int MenuLines = 7;

	////////////////////
	// Navigator states
	typedef enum logic [3:0]
	{
		RefreshTitle,
		RefreshOption,
		WaitRefresh,
		WaitSelection,
		ShowLocal,
		WaitReturn,
		PosSelect,
		CharSelect,
		WaitChar,
		ClearRam
	} navState_t;

	// User controls, all single-cycle pulses
	typedef struct packed
	{
		logic rotaryEvent;
		logic rotaryLeft;     // Direction of rotaryEvent
		logic rotaryBtn;
		logic menuBtn;
		logic colLeftBtn;
		logic colRightBtn;
	} userInput_t;

	// Starting character is the letter A
	localparam logic [3:0] DefaultColumn = 4'd4;
	localparam logic [3:0] DefaultRow = 4'd1;
	localparam logic [7:0] SpaceChar = 8'h20;

endpackage

//--- source/lcdPkg.sv
package lcdPkg;

	////////////////////
	// Display geometry
	localparam int LineLength = 16;
	localparam int ScreenLength = 32;

	// Screen and RAM position
	typedef logic [4:0] addr_t;
	typedef logic [7:0] char_t;

	// Kinds of screen refresh
	typedef enum logic [1:0]
	{
		RomLine,      // One menu line
		RamPage,      // Whole local RAM
		SingleChar    // One given character
	} lcdOp_t;

	// Stop address is derived by the writer
	typedef struct packed
	{
		lcdOp_t op;
		logic [2:0] menuId;
		addr_t startAddr;
		char_t charData;
	} refreshReq_t;

	typedef struct packed
	{
		addr_t addr;
		char_t data;
	} lcdWrite_t;

	typedef struct packed
	{
		addr_t addr;
		char_t data;
	} ramWrite_t;

endpackage

//--- source/menuTextRom.sv
`timescale 1ns/1ps

module menuTextRom
	import menuPkg::*, lcdPkg::*;
(
	input logic clk,
	input menuId_t line,
	input logic [3:0] offset,
	output char_t data
);

	// Lines stored back to back, 16 characters each
	char_t rom [0:MenuLines*LineLength-1];

	// Line number in the upper bits, character in the lower
	logic [6:0] romIndex;

	initial
	begin
		$readmemh("source/menuText.mem", rom);
	end

	assign romIndex = {line, offset};

	// Registered read
	always_ff @(posedge clk)
	begin
		data <= rom[romIndex];
	end

endmodule

//--- source/textRam.sv
`timescale 1ns/1ps

module textRam
	import menuPkg::*, lcdPkg::*;
(
	input logic clk,
	input logic rst,
	input ramWrite_t wr,
	input logic we,
	input logic clear,
	input addr_t rdAddr,
	output char_t rdData
);

	// One character per screen position
	char_t mem [0:ScreenLength-1];

	////////////////////
	// Write side

	// Clear wins over a write in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst || clear)
		begin
			// Whole buffer back to blanks in one edge
			for (int i = 0; i < ScreenLength; i++)
			begin
				mem[i] <= SpaceChar;
			end
		end
		else if (we)
		begin
			mem[wr.addr] <= wr.data;
		end
	end

	////////////////////
	// Read side

	// Data one cycle after the address
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

//--- source/lcdWriter.sv
`timescale 1ns/1ps

module lcdWriter
	import menuPkg::*, lcdPkg::*;
(
	input logic clk,
	input logic rst,
	input refreshReq_t req,
	input logic reqStrobe,
	output menuId_t romLine,
	output logic [3:0] romOffset,
	input char_t romData,
	output addr_t ramAddr,
	input char_t ramData,
	output lcdWrite_t lcd,
	output logic lcdWe,
	output logic done
);

	// Fetch cycle then write cycle per character
	typedef enum logic [1:0] {WrIdle, WrFetch, WrData} phase_t;

	phase_t phase;
	refreshReq_t active;     // Request being executed
	addr_t curAddr;
	addr_t stopAddr;
	logic [3:0] offset;      // Character index within a ROM line

	////////////////////
	// Sequencing
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase <= WrIdle;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (phase)
				WrIdle:
				begin
					if (reqStrobe)
						phase <= WrFetch;
				end
				WrFetch:
					phase <= WrData;
				WrData:
				begin
					// Last character written
					if (curAddr == stopAddr)
					begin
						phase <= WrIdle;
						done <= 1'b1;
					end
					else
						phase <= WrFetch;
				end
				default:
					phase <= WrIdle;
			endcase
		end
	end

	// Latch request and walk the addresses
	always_ff @(posedge clk)
	begin
		if (phase == WrIdle && reqStrobe)
		begin
			active <= req;
			offset <= '0;
			case (req.op)
				RomLine:
				begin
					curAddr <= req.startAddr;
					stopAddr <= req.startAddr + addr_t'(LineLength - 1);
				end
				RamPage:
				begin
					// Full page always starts at the top left
					curAddr <= '0;
					stopAddr <= addr_t'(ScreenLength - 1);
				end
				default:
				begin
					curAddr <= req.startAddr;
					stopAddr <= req.startAddr;
				end
			endcase
		end
		else if (phase == WrData)
		begin
			curAddr <= curAddr + 1'b1;
			offset <= offset + 1'b1;
		end
	end

	// Source addresses
	assign romLine = menuId_t'(active.menuId);
	assign romOffset = offset;
	assign ramAddr = curAddr;

	////////////////////
	// LCD side
	assign lcdWe = (phase == WrData);
	assign lcd.addr = curAddr;

	// Pick data source by opcode
	always_comb
	begin
		case (active.op)
			RomLine: lcd.data = romData;
			RamPage: lcd.data = ramData;
			default: lcd.data = active.charData;
		endcase
	end

endmodule

//--- source/menuNavigator.sv
`timescale 1ns/1ps

module menuNavigator
	import menuPkg::*, lcdPkg::*;
(
	input logic clk,
	input logic rst,
	input userInput_t user,
	input logic done,
	output refreshReq_t req,
	output logic reqStrobe,
	output ramWrite_t ramWr,
	output logic ramWe,
	output logic ramClear
);

	navState_t state;
	navState_t nextState;    // Where to go after the refresh
	menuId_t option;         // Option line on screen
	addr_t charPos;          // Edit position
	logic [3:0] charColumn;
	logic [3:0] charRow;
	char_t lastChar;         // Character last sent to the LCD
	char_t curChar;

	// Column is the upper nibble of the code
	assign curChar = {charColumn, charRow};

	////////////////////
	// Helpers

	// Cyclic option order, Yes and No just toggle
	function automatic menuId_t stepOption(menuId_t opt, logic forward);
		menuId_t result;
		case (opt)
			OptDisplayLocal: result = forward ? OptModifyLocal : OptClearLocal;
			OptModifyLocal: result = forward ? OptClearLocal : OptDisplayLocal;
			OptClearLocal: result = forward ? OptDisplayLocal : OptModifyLocal;
			OptYes: result = OptNo;
			OptNo: result = OptYes;
			default: result = OptDisplayLocal;
		endcase
		return result;
	endfunction

	// Confirm options sit under their own title
	function automatic menuId_t titleFor(menuId_t opt);
		if (opt == OptYes || opt == OptNo)
			return TitleSure;
		return TitleMain;
	endfunction

	// Printable columns only, 2 to 7 and 10 to 15
	function automatic logic [3:0] stepColumn(logic [3:0] col, logic right);
		logic [3:0] result;
		if (right)
		begin
			case (col)
				4'd7: result = 4'd10;
				4'd15: result = 4'd2;
				default: result = col + 4'd1;
			endcase
		end
		else
		begin
			case (col)
				4'd10: result = 4'd7;
				4'd2: result = 4'd15;
				default: result = col - 4'd1;
			endcase
		end
		return result;
	endfunction

	////////////////////
	// Main FSM
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= RefreshTitle;
			nextState <= RefreshOption;
			option <= OptDisplayLocal;
			charPos <= '0;
			charColumn <= DefaultColumn;
			charRow <= DefaultRow;
			lastChar <= {DefaultColumn, DefaultRow};
			reqStrobe <= 1'b0;
			ramWe <= 1'b0;
			ramClear <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			reqStrobe <= 1'b0;
			ramWe <= 1'b0;
			ramClear <= 1'b0;
			// Menu button escapes anywhere but a wait
			if (user.menuBtn && state != WaitRefresh && state != WaitChar)
			begin
				state <= RefreshTitle;
				option <= OptDisplayLocal;
				charPos <= '0;
				charColumn <= DefaultColumn;
				charRow <= DefaultRow;
				lastChar <= {DefaultColumn, DefaultRow};
			end
			else
			begin
				case (state)
					RefreshTitle:
					begin
						// Top line of the screen
						req <= '{RomLine, titleFor(option), addr_t'(0), SpaceChar};
						reqStrobe <= 1'b1;
						nextState <= RefreshOption;
						state <= WaitRefresh;
					end
					RefreshOption:
					begin
						// Bottom line
						req <= '{RomLine, option, addr_t'(LineLength), SpaceChar};
						reqStrobe <= 1'b1;
						nextState <= WaitSelection;
						state <= WaitRefresh;
					end
					ShowLocal:
					begin
						// Return target already set by the caller
						req <= '{RamPage, option, addr_t'(0), SpaceChar};
						reqStrobe <= 1'b1;
						state <= WaitRefresh;
					end
					WaitRefresh:
					begin
						if (done)
							state <= nextState;
					end
					WaitSelection:
					begin
						if (user.rotaryBtn)
						begin
							case (option)
								OptDisplayLocal:
								begin
									nextState <= WaitReturn;
									state <= ShowLocal;
								end
								OptModifyLocal:
								begin
									// Show the buffer before editing it
									nextState <= PosSelect;
									state <= ShowLocal;
								end
								OptClearLocal:
								begin
									option <= OptYes;
									state <= RefreshTitle;
								end
								OptYes:
									state <= ClearRam;
								default:
								begin
									option <= OptDisplayLocal;
									state <= RefreshTitle;
								end
							endcase
						end
						else if (user.rotaryEvent)
						begin
							option <= stepOption(option, user.rotaryLeft);
							state <= RefreshTitle;
						end
					end
					WaitReturn:
					begin
						if (user.rotaryBtn)
						begin
							option <= OptDisplayLocal;
							state <= RefreshTitle;
						end
					end
					PosSelect:
					begin
						if (user.rotaryBtn)
							state <= CharSelect;
						else if (user.rotaryEvent)
							charPos <= user.rotaryLeft ? charPos + 1'b1 : charPos - 1'b1;
					end
					CharSelect:
					begin
						// Changed character goes out first
						if (curChar != lastChar)
						begin
							req <= '{SingleChar, option, charPos, curChar};
							reqStrobe <= 1'b1;
							lastChar <= curChar;
							state <= WaitChar;
						end
						else if (user.rotaryBtn)
						begin
							// Commit to the buffer
							ramWr <= '{charPos, curChar};
							ramWe <= 1'b1;
							state <= PosSelect;
						end
						else if (user.rotaryEvent)
							charRow <= user.rotaryLeft ? charRow + 4'd1 : charRow - 4'd1;
						else if (user.colLeftBtn)
							charColumn <= stepColumn(charColumn, 1'b0);
						else if (user.colRightBtn)
							charColumn <= stepColumn(charColumn, 1'b1);
					end
					WaitChar:
					begin
						if (done)
							state <= CharSelect;
					end
					ClearRam:
					begin
						// Blank the buffer and go home
						ramClear <= 1'b1;
						option <= OptDisplayLocal;
						state <= RefreshTitle;
					end
					default:
						state <= RefreshTitle;
				endcase
			end
		end
	end

endmodule

//--- source/lcdMenu.sv
`timescale 1ns/1ps

module lcdMenu
	import menuPkg::*, lcdPkg::*;
(
	input logic clk,
	input logic rst,
	input userInput_t user,
	output lcdWrite_t lcd,
	output logic lcdWe
);

	////////////////////
	// Navigator to writer
	refreshReq_t req;
	logic reqStrobe;
	logic done;

	// Navigator to RAM
	ramWrite_t ramWr;
	logic ramWe;
	logic ramClear;

	// Writer read ports
	addr_t ramAddr;
	char_t ramData;
	menuId_t romLine;
	logic [3:0] romOffset;
	char_t romData;

	menuNavigator uNavigator
	(
		.clk(clk),
		.rst(rst),
		.user(user),
		.done(done),
		.req(req),
		.reqStrobe(reqStrobe),
		.ramWr(ramWr),
		.ramWe(ramWe),
		.ramClear(ramClear)
	);

	// Local text buffer
	textRam uTextRam
	(
		.clk(clk),
		.rst(rst),
		.wr(ramWr),
		.we(ramWe),
		.clear(ramClear),
		.rdAddr(ramAddr),
		.rdData(ramData)
	);

	menuTextRom uMenuRom
	(
		.clk(clk),
		.line(romLine),
		.offset(romOffset),
		.data(romData)
	);

	lcdWriter uWriter
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.reqStrobe(reqStrobe),
		.romLine(romLine),
		.romOffset(romOffset),
		.romData(romData),
		.ramAddr(ramAddr),
		.ramData(ramData),
		.lcd(lcd),
		.lcdWe(lcdWe),
		.done(done)
	);

endmodule

//--- verification/lcdMenu_checker.sv
`timescale 1ns/1ps

module lcdMenu_checker
	import lcdPkg::*;
(
	input logic clk,
	input logic rst,
	input refreshReq_t req,
	input logic reqStrobe,
	input logic lcdWe,
	input logic done
);

	// Request open from strobe until done
	logic busy;
	// Writes the open request still owes
	logic [5:0] owed;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			owed <= '0;
		end
		else if (reqStrobe)
		begin
			busy <= 1'b1;
			// Write count per opcode
			case (req.op)
				RomLine: owed <= 6'(LineLength);
				RamPage: owed <= 6'(ScreenLength);
				default: owed <= 6'd1;
			endcase
		end
		else
		begin
			if (done)
				busy <= 1'b0;
			if (lcdWe && owed != 6'd0)
				owed <= owed - 6'd1;
		end
	end

	////////////////////
	// Handshake
	strobeWhenIdle: assert property (@(posedge clk) disable iff (rst) reqStrobe |-> !busy)
		else $error("reqStrobe while a request is in progress");

	// Done one cycle after the final write of the request
	doneAfterWrite: assert property (@(posedge clk) disable iff (rst)
		done |-> ($past(lcdWe) && owed == 6'd0))
		else $error("done not one cycle after the last write of a request");

	////////////////////
	// LCD side

	// Fetch cycle between any two writes
	noBackToBack: assert property (@(posedge clk) disable iff (rst) lcdWe |=> !lcdWe)
		else $error("lcdWe high in two consecutive cycles");

endmodule

// Attached to every writer
bind lcdWriter lcdMenu_checker uChecker
(
	.clk(clk),
	.rst(rst),
	.req(req),
	.reqStrobe(reqStrobe),
	.lcdWe(lcdWe),
	.done(done)
);

//--- verification/lcdMenuTb.sv
`timescale 1ns/1ps

module lcdMenuTb
	import menuPkg::*, lcdPkg::*;
();

	// What the model expects on screen
	typedef enum logic [1:0] {KindMenu, KindPage, KindChar} screenKind_t;

	logic clk;
	logic rst;
	userInput_t user;
	lcdWrite_t lcd;
	logic lcdWe;

	// Own copy of menu text, model of the local RAM
	logic [7:0] menuText [0:MenuLines*LineLength-1];
	logic [7:0] modelRam [0:ScreenLength-1];

	// Expected writes in order
	logic [4:0] expAddr [$];
	logic [7:0] expData [$];
	logic [4:0] wantAddr;
	logic [7:0] wantData;

	// Navigator model
	menuId_t modelOption;
	logic [4:0] modelPos;
	logic [3:0] modelRow;
	int modelColIdx;
	int defaultColIdx;
	logic [3:0] columns [0:11];   // Printable columns in step order

	int seed;
	int randVal;
	int steps;
	logic dir;
	int errorCount;
	int writeCount;
	int testCount;
	int failedTests;
	int testErrStart;

	lcdMenu UUT
	(
		.clk(clk),
		.rst(rst),
		.user(user),
		.lcd(lcd),
		.lcdWe(lcdWe)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	////////////////////
	// Reference model

	// Expected character at one screen address
	function automatic logic [7:0] refChar(screenKind_t kind, menuId_t title, menuId_t opt,
		logic [7:0] single, logic [7:0] ram [0:ScreenLength-1], logic [4:0] addr);
		int line;
		logic [7:0] result;
		case (kind)
			KindMenu:
			begin
				// Title on the upper row, option below
				line = (addr < LineLength) ? int'(title) : int'(opt);
				result = menuText[line * LineLength + int'(addr) % LineLength];
			end
			KindPage:
				result = ram[addr];
			default:
				result = single;
		endcase
		return result;
	endfunction

	// Left turns move forward through the three options
	function automatic menuId_t nextOption(menuId_t opt, logic left);
		menuId_t order [0:2];
		int idx;
		order = '{OptDisplayLocal, OptModifyLocal, OptClearLocal};
		idx = 0;
		for (int i = 0; i < 3; i++)
		begin
			if (order[i] == opt)
				idx = i;
		end
		idx = left ? (idx + 1) % 3 : (idx + 2) % 3;
		return order[idx];
	endfunction

	// Column in the upper nibble
	function automatic logic [7:0] modelChar();
		return {columns[modelColIdx], modelRow};
	endfunction

	task automatic expectScreen(screenKind_t kind, menuId_t title, menuId_t opt,
		logic [4:0] pos, logic [7:0] single);
		int first;
		int count;
		first = (kind == KindChar) ? int'(pos) : 0;
		count = (kind == KindChar) ? 1 : ScreenLength;
		for (int i = first; i < first + count; i++)
		begin
			expAddr.push_back(5'(i));
			expData.push_back(refChar(kind, title, opt, single, modelRam, 5'(i)));
		end
	endtask

	////////////////////
	// Compare every LCD write
	always @(negedge clk)
	begin
		if (!rst && lcdWe === 1'b1)
		begin
			writeCount++;
			if (expAddr.size() == 0)
			begin
				$display("Unexpected LCD write of %h at address %h", lcd.data, lcd.addr);
				errorCount++;
			end
			else
			begin
				wantAddr = expAddr.pop_front();
				wantData = expData.pop_front();
				if (lcd.addr !== wantAddr)
				begin
					$display("mismatch lcd.addr expected %h got %h", wantAddr, lcd.addr);
					errorCount++;
				end
				if (lcd.data !== wantData)
				begin
					$display("mismatch lcd.data at %h expected %h got %h", wantAddr, wantData,
						lcd.data);
					errorCount++;
				end
			end
		end
	end

	////////////////////
	// Stimulus helpers

	// Inputs change 2 ns after the edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic pulse(userInput_t u);
		user = u;
		nextCycle();
		user = '0;
	endtask

	task automatic rotate(logic left);
		userInput_t u;
		u = '0;
		u.rotaryEvent = 1'b1;
		u.rotaryLeft = left;
		pulse(u);
	endtask

	task automatic pressRotary();
		userInput_t u;
		u = '0;
		u.rotaryBtn = 1'b1;
		pulse(u);
	endtask

	task automatic pressColumn(logic right);
		userInput_t u;
		u = '0;
		u.colRightBtn = right;
		u.colLeftBtn = !right;
		pulse(u);
	endtask

	// All expected writes seen, or give up
	task automatic waitScreen();
		int waited;
		waited = 0;
		while (expAddr.size() != 0 && waited < ScreenLength * 4)
		begin
			nextCycle();
			waited++;
		end
		if (expAddr.size() != 0)
		begin
			$display("LCD writes stopped early with %0d writes still expected", expAddr.size());
			errorCount++;
			expAddr.delete();
			expData.delete();
		end
		// Done and the state change follow the last write
		repeat (4) nextCycle();
	endtask

	// Menu button back to the main menu with defaults
	task automatic goHome();
		userInput_t u;
		u = '0;
		u.menuBtn = 1'b1;
		pulse(u);
		modelOption = OptDisplayLocal;
		modelPos = '0;
		modelRow = DefaultRow;
		modelColIdx = defaultColIdx;
		expectScreen(KindMenu, TitleMain, modelOption, 5'd0, 8'h00);
		waitScreen();
	endtask

	// Yes and No toggle, main options cycle
	task automatic rotateMenu(logic left);
		rotate(left);
		if (modelOption == OptYes || modelOption == OptNo)
		begin
			modelOption = (modelOption == OptYes) ? OptNo : OptYes;
			expectScreen(KindMenu, TitleSure, modelOption, 5'd0, 8'h00);
		end
		else
		begin
			modelOption = nextOption(modelOption, left);
			expectScreen(KindMenu, TitleMain, modelOption, 5'd0, 8'h00);
		end
		waitScreen();
	endtask

	// Rotary press that lands on a menu screen
	task automatic selectToMenu(menuId_t title, menuId_t opt);
		pressRotary();
		modelOption = opt;
		expectScreen(KindMenu, title, opt, 5'd0, 8'h00);
		waitScreen();
	endtask

	// Display Local from the main menu and back
	task automatic showLocal();
		pressRotary();
		expectScreen(KindPage, TitleMain, modelOption, 5'd0, 8'h00);
		waitScreen();
		selectToMenu(TitleMain, OptDisplayLocal);
	endtask

	// Editor steps
	task automatic movePos(logic left);
		rotate(left);
		modelPos = left ? modelPos + 5'd1 : modelPos - 5'd1;
	endtask

	task automatic moveRow(logic left);
		rotate(left);
		modelRow = left ? modelRow + 4'd1 : modelRow - 4'd1;
		expectScreen(KindChar, TitleMain, modelOption, modelPos, modelChar());
		waitScreen();
	endtask

	task automatic moveColumn(logic right);
		pressColumn(right);
		modelColIdx = right ? (modelColIdx + 1) % 12 : (modelColIdx + 11) % 12;
		expectScreen(KindChar, TitleMain, modelOption, modelPos, modelChar());
		waitScreen();
	endtask

	// RAM write only, no LCD traffic
	task automatic commitChar();
		pressRotary();
		modelRam[modelPos] = modelChar();
		repeat (2) nextCycle();
	endtask

	task automatic startTest();
		testErrStart = errorCount;
		testCount++;
	endtask

	task automatic endTest(string name);
		if (errorCount == testErrStart)
			$display("Test %0d %s: ok", testCount, name);
		else
		begin
			$display("Test %0d %s: failed with %0d errors", testCount, name,
				errorCount - testErrStart);
			failedTests++;
		end
	endtask

	////////////////////
	// Test sequence
	initial
	begin
		seed = 72522;
		errorCount = 0;
		writeCount = 0;
		testCount = 0;
		failedTests = 0;
		user = '0;
		rst = 1'b1;
		columns = '{4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15};
		defaultColIdx = 0;
		for (int i = 0; i < 12; i++)
		begin
			if (columns[i] == DefaultColumn)
				defaultColIdx = i;
		end
		for (int i = 0; i < ScreenLength; i++)
		begin
			modelRam[i] = SpaceChar;
		end
		$readmemh("source/menuText.mem", menuText);
		modelOption = OptDisplayLocal;
		modelPos = '0;
		modelRow = DefaultRow;
		modelColIdx = defaultColIdx;

		// Power-up screen
		startTest();
		expectScreen(KindMenu, TitleMain, OptDisplayLocal, 5'd0, 8'h00);
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		waitScreen();
		endTest("reset screen");

		// Random walk through the options
		startTest();
		randVal = $random(seed);
		steps = 5 + $unsigned(randVal) % 4;
		for (int s = 0; s < steps; s++)
		begin
			randVal = $random(seed);
			dir = randVal[0];
			rotateMenu(dir);
		end
		goHome();
		endTest("random rotation");

		// Blank buffer after reset
		startTest();
		showLocal();
		endTest("display local");

		// Editor, both position wraps and both column wraps
		startTest();
		rotateMenu(1'b1);
		pressRotary();
		expectScreen(KindPage, TitleMain, modelOption, 5'd0, 8'h00);
		waitScreen();
		movePos(1'b0);
		pressRotary();
		moveRow(1'b1);
		for (int k = 0; k < 3; k++)
		begin
			moveRow(1'b0);
		end
		for (int k = 0; k < 4; k++)
		begin
			moveColumn(1'b1);
		end
		moveColumn(1'b0);
		moveColumn(1'b1);
		for (int k = 0; k < 6; k++)
		begin
			moveColumn(1'b1);
		end
		moveColumn(1'b0);
		commitChar();
		// Second character two places on
		movePos(1'b1);
		movePos(1'b1);
		pressRotary();
		moveRow(1'b1);
		commitChar();
		goHome();
		showLocal();
		endTest("modify local");

		// Clear, first declined then confirmed
		startTest();
		rotateMenu(1'b0);
		selectToMenu(TitleSure, OptYes);
		rotateMenu(1'b1);
		selectToMenu(TitleMain, OptDisplayLocal);
		showLocal();
		rotateMenu(1'b0);
		selectToMenu(TitleSure, OptYes);
		rotateMenu(1'b0);
		rotateMenu(1'b1);
		for (int i = 0; i < ScreenLength; i++)
		begin
			modelRam[i] = SpaceChar;
		end
		selectToMenu(TitleMain, OptDisplayLocal);
		showLocal();
		endTest("clear local");

		$display("Tests run %0d, failed %0d, LCD writes %0d, errors %0d", testCount,
			failedTests, writeCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- lcdMenu.f
source/menuPkg.sv
source/lcdPkg.sv
source/menuTextRom.sv
source/textRam.sv
source/lcdWriter.sv
source/menuNavigator.sv
source/lcdMenu.sv
verification/lcdMenu_checker.sv
verification/lcdMenuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the lcdMenu testbench with Verilator

verilator --binary --timing --assert -Wno-fatal \
	--top-module lcdMenuTb -f lcdMenu.f -o lcdMenuSim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/lcdMenuSim > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log

# An assertion stop leaves no closing message either
grep -q "Finished with errors" sim.log && { echo "FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAILED"; exit 1; }
echo "PASSED"

//--- source/menuText.mem
// One menu line per row, 16 ASCII codes in hex, row number is the menuId value
4D 61 69 6E 20 4D 65 6E 75 20 20 20 20 20 20 20
3E 20 44 69 73 70 6C 61 79 20 4C 6F 63 61 6C 20
3E 20 4D 6F 64 69 66 79 20 4C 6F 63 61 6C 20 20
3E 20 43 6C 65 61 72 20 4C 6F 63 61 6C 20 20 20
41 72 65 20 79 6F 75 20 73 75 72 65 3F 20 20 20
3E 20 59 65 73 20 20 20 20 20 20 20 20 20 20 20
3E 20 4E 6F 20 20 20 20 20 20 20 20 20 20 20 20
